/* logic/matmul_pkg.sv */
`default_nettype none

package matmul_pkg;

  // array size, lanes per word and words per matrix
  localparam int dim = 4;
  localparam int data_width = 16;
  localparam int addr_width = 7;
  localparam int mem_depth = 128;

  // edges from the first start sample until done is seen high
  localparam int compute_cycles = 4 * dim;

  // one memory word, lane i in element i
  typedef logic [dim-1:0][data_width-1:0] lane_word_t;

  typedef enum logic [1:0] {
    op_idle,
    op_write_a,
    op_write_b,
    op_read_c
  } host_op_e;

  typedef struct packed {
    host_op_e               op;
    logic [addr_width-1:0]  addr;
    lane_word_t             data;
  } host_req_t;

  typedef enum logic [1:0] {
    st_idle,
    st_feed,
    st_drain,
    st_done
  } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/word_ram.sv */
`default_nettype none

module word_ram #(
  parameter int addr_width = matmul_pkg::addr_width,
  parameter int depth = matmul_pkg::mem_depth
) (
  input  logic                   clk,
  input  logic                   we,
  input  logic [addr_width-1:0]  addr,
  input  matmul_pkg::lane_word_t wdata,
  output matmul_pkg::lane_word_t rdata
);

  matmul_pkg::lane_word_t mem [depth];

  // power-up contents are zero
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // write-first, read data registered
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* logic/processing_element.sv */
`default_nettype none

module processing_element #(
  parameter int data_width = matmul_pkg::data_width
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  logic [data_width-1:0] in_a,
  input  logic [data_width-1:0] in_b,
  input  logic [data_width-1:0] in_c,
  input  logic                  select,
  output logic [data_width-1:0] out_a,
  output logic [data_width-1:0] out_b,
  output logic [data_width-1:0] out_c
);

  logic [2*data_width-1:0] acc;
  logic [2*data_width-1:0] product;
  logic [data_width-1:0]   acc_sat;

  assign product = in_a * in_b;

  // any upper bit set means the result does not fit
  assign acc_sat = (|acc[2*data_width-1:data_width]) ? '1 : acc[data_width-1:0];

  // selected cell puts its result on the row chain, others pass it on
  assign out_c = select ? acc_sat : in_c;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
      acc <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      if (clear) begin
        acc <= '0;
      end else begin
        acc <= acc + product;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/systolic_array.sv */
`default_nettype none

module systolic_array #(
  parameter int dim = matmul_pkg::dim,
  parameter int data_width = matmul_pkg::data_width
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   feed_en,
  input  matmul_pkg::lane_word_t a_word,
  input  matmul_pkg::lane_word_t b_word,
  output matmul_pkg::lane_word_t result_word,
  output logic                   result_valid
);

  localparam int cnt_last = 3 * dim - 1;
  localparam int cnt_width = $clog2(cnt_last + 1);

  // a and b of one lane move through the skew together
  typedef struct packed {
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
  } operand_t;

  operand_t              skewed [dim];
  logic [data_width-1:0] a_h [dim][dim+1];
  logic [data_width-1:0] b_v [dim+1][dim];
  logic [data_width-1:0] c_h [dim][dim+1];
  logic [cnt_width-1:0]  cnt;

  // counts from the first feed cycle and parks at cnt_last
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      cnt <= '0;
    end else if ((feed_en || cnt != '0) && cnt != cnt_width'(cnt_last)) begin
      cnt <= cnt + 1'b1;
    end
  end

  // C words leave the deskew on consecutive counts
  assign result_valid = (cnt >= cnt_width'(2 * dim - 1)) && (cnt <= cnt_width'(3 * dim - 2));

  for (genvar r = 0; r < dim; r++) begin : g_skew
    operand_t lane_in;

    assign lane_in.a = feed_en ? a_word[r] : '0;
    assign lane_in.b = feed_en ? b_word[r] : '0;

    if (r == 0) begin : g_direct
      assign skewed[r] = lane_in;
    end else begin : g_delay
      operand_t dly [r];

      // lane r waits r cycles
      always_ff @(posedge clk) begin
        if (reset) begin
          for (int i = 0; i < r; i++) begin
            dly[i] <= '0;
          end
        end else begin
          dly[0] <= lane_in;
          for (int i = 1; i < r; i++) begin
            dly[i] <= dly[i-1];
          end
        end
      end

      assign skewed[r] = dly[r-1];
    end

    assign a_h[r][0] = skewed[r].a;
    assign b_v[0][r] = skewed[r].b;
    assign c_h[r][dim] = '0;
  end

  for (genvar r = 0; r < dim; r++) begin : g_row
    for (genvar c = 0; c < dim; c++) begin : g_col
      // C[r][c] is final at count dim + r + c
      processing_element #(
        .data_width(data_width)
      ) u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_h[r][c]),
        .in_b  (b_v[r][c]),
        .in_c  (c_h[r][c+1]),
        .select(cnt == cnt_width'(dim + r + c)),
        .out_a (a_h[r][c+1]),
        .out_b (b_v[r+1][c]),
        .out_c (c_h[r][c])
      );
    end
  end

  // row r is early by dim-1-r cycles
  for (genvar r = 0; r < dim; r++) begin : g_deskew
    if (r == dim - 1) begin : g_direct
      assign result_word[r] = c_h[r][0];
    end else begin : g_delay
      logic [data_width-1:0] dly [dim-1-r];

      always_ff @(posedge clk) begin
        dly[0] <= c_h[r][0];
        for (int i = 1; i < dim - 1 - r; i++) begin
          dly[i] <= dly[i-1];
        end
      end

      assign result_word[r] = dly[dim-2-r];
    end
  end

  a_valid_after_feed: assert property (
    @(posedge clk) disable iff (reset)
    $rose(result_valid) |-> !feed_en && $past(!feed_en, dim - 1)
  );

endmodule

`default_nettype wire

/* logic/matmul_controller.sv */
`default_nettype none

module matmul_controller #(
  parameter int dim = matmul_pkg::dim,
  parameter int addr_width = matmul_pkg::addr_width
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  result_valid,
  output logic [addr_width-1:0] feed_addr,
  output logic                  feed_en,
  output logic                  clear,
  output logic [addr_width-1:0] c_addr,
  output logic                  c_we,
  output logic                  done
);

  localparam int cnt_width = $clog2(matmul_pkg::compute_cycles + 1);

  matmul_pkg::ctrl_state_e state;
  logic [cnt_width-1:0]    cycle_cnt;
  logic [cnt_width-1:0]    feed_idx;

  // cycle_cnt counts edges seen with start high
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      state <= matmul_pkg::st_idle;
      cycle_cnt <= '0;
      c_addr <= '0;
      feed_en <= 1'b0;
    end else begin
      // memory read data trails the feed address by one cycle
      feed_en <= (state == matmul_pkg::st_feed);
      if (state != matmul_pkg::st_done) begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
      case (state)
        matmul_pkg::st_idle: begin
          state <= matmul_pkg::st_feed;
        end
        matmul_pkg::st_feed: begin
          if (cycle_cnt == cnt_width'(dim)) begin
            state <= matmul_pkg::st_drain;
          end
        end
        matmul_pkg::st_drain: begin
          if (result_valid) begin
            c_addr <= c_addr + 1'b1;
          end
          // all words written and the fixed latency reached
          if (c_addr == addr_width'(dim) &&
              cycle_cnt == cnt_width'(matmul_pkg::compute_cycles - 1)) begin
            state <= matmul_pkg::st_done;
          end
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

  assign feed_idx = cycle_cnt - 1'b1;
  assign feed_addr = addr_width'(feed_idx);

  // one cycle, just before the feed starts
  assign clear = (state == matmul_pkg::st_idle) && start;
  assign c_we = (state == matmul_pkg::st_drain) && result_valid;
  assign done = (state == matmul_pkg::st_done);

  a_done_latency: assert property (
    @(posedge clk) disable iff (reset || !start)
    $rose(start) |-> (!done) [*matmul_pkg::compute_cycles] ##1 done
  );

endmodule

`default_nettype wire

/* logic/matmul_top.sv */
`default_nettype none

module matmul_top #(
  parameter int data_width = matmul_pkg::data_width,
  parameter int dim = matmul_pkg::dim,
  parameter int addr_width = matmul_pkg::addr_width
) (
  input  logic                   clk,
  input  logic                   reset,
  input  matmul_pkg::host_req_t  host_req,
  input  logic                   start,
  output matmul_pkg::lane_word_t rd_data,
  output logic                   done
);

  matmul_pkg::host_req_t  host_q;
  logic [addr_width-1:0]  rd_addr_q;
  logic                   we_a;
  logic                   we_b;
  logic [addr_width-1:0]  addr_a;
  logic [addr_width-1:0]  addr_b;
  logic [addr_width-1:0]  addr_c;
  logic [addr_width-1:0]  feed_addr;
  logic [addr_width-1:0]  c_addr;
  logic                   feed_en;
  logic                   clear;
  logic                   c_we;
  logic                   result_valid;
  matmul_pkg::lane_word_t a_word;
  matmul_pkg::lane_word_t b_word;
  matmul_pkg::lane_word_t result_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      host_q.op <= matmul_pkg::op_idle;
    end else begin
      host_q.op <= host_req.op;
    end
  end

  // read address held so rd_data keeps the last word between reads
  always_ff @(posedge clk) begin
    host_q.addr <= host_req.addr;
    host_q.data <= host_req.data;
    if (host_req.op == matmul_pkg::op_read_c) begin
      rd_addr_q <= host_req.addr;
    end
  end

  assign we_a = (host_q.op == matmul_pkg::op_write_a);
  assign we_b = (host_q.op == matmul_pkg::op_write_b);

  // host owns A and B only while writing them
  assign addr_a = we_a ? host_q.addr : feed_addr;
  assign addr_b = we_b ? host_q.addr : feed_addr;
  assign addr_c = c_we ? c_addr : rd_addr_q;

  word_ram #(
    .addr_width(addr_width),
    .depth     (matmul_pkg::mem_depth)
  ) mem_a (
    .clk  (clk),
    .we   (we_a),
    .addr (addr_a),
    .wdata(host_q.data),
    .rdata(a_word)
  );

  word_ram #(
    .addr_width(addr_width),
    .depth     (matmul_pkg::mem_depth)
  ) mem_b (
    .clk  (clk),
    .we   (we_b),
    .addr (addr_b),
    .wdata(host_q.data),
    .rdata(b_word)
  );

  word_ram #(
    .addr_width(addr_width),
    .depth     (matmul_pkg::mem_depth)
  ) mem_c (
    .clk  (clk),
    .we   (c_we),
    .addr (addr_c),
    .wdata(result_word),
    .rdata(rd_data)
  );

  matmul_controller #(
    .dim       (dim),
    .addr_width(addr_width)
  ) u_controller (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .result_valid(result_valid),
    .feed_addr   (feed_addr),
    .feed_en     (feed_en),
    .clear       (clear),
    .c_addr      (c_addr),
    .c_we        (c_we),
    .done        (done)
  );

  systolic_array #(
    .dim       (dim),
    .data_width(data_width)
  ) u_array (
    .clk         (clk),
    .reset       (reset),
    .clear       (clear),
    .feed_en     (feed_en),
    .a_word      (a_word),
    .b_word      (b_word),
    .result_word (result_word),
    .result_valid(result_valid)
  );

  // a registered host write would collide with the first feed read
  a_no_host_during_start: assert property (
    @(posedge clk) disable iff (reset)
    start |-> (host_req.op == matmul_pkg::op_idle) && (host_q.op == matmul_pkg::op_idle)
  );

endmodule

`default_nettype wire

/* test/matmul_tasks.svh */
`ifndef MATMUL_TASKS_SVH
`define MATMUL_TASKS_SVH

task automatic compare_lane(string name, logic [15:0] got, logic [15:0] exp);
  assert (got === exp)
  else stop_with_failure($sformatf("Fail %s: got %0h expected %0h", name, got, exp));
endtask

// zero bits leaves that matrix as it is
task automatic randomize_matrices(int a_bits, int b_bits);
  for (int r = 0; r < dim; r++) begin
    for (int c = 0; c < dim; c++) begin
      if (a_bits > 0) a_mat[r][c] = random_bits(a_bits);
      if (b_bits > 0) b_mat[r][c] = random_bits(b_bits);
    end
  end
endtask

// A word k is column k of A, B word k is row k of B
task automatic write_matrices(bit write_a, bit write_b);
  matmul_pkg::lane_word_t word;
  for (int k = 0; k < dim; k++) begin
    for (int m = 0; m < 2; m++) begin
      if ((m == 0 && write_a) || (m == 1 && write_b)) begin
        for (int r = 0; r < dim; r++) begin
          word[r] = (m == 0) ? a_mat[r][k] : b_mat[k][r];
        end
        @(posedge clk);
        host_req.op <= (m == 0) ? matmul_pkg::op_write_a : matmul_pkg::op_write_b;
        host_req.addr <= addr_width'(k);
        host_req.data <= word;
      end
    end
  end
  @(posedge clk);
  host_req <= '0;
  @(posedge clk);
endtask

task automatic run_compute();
  int n;
  n = 0;
  @(posedge clk);
  start <= 1'b1;
  // edges with start high until done shows up
  while (n < matmul_pkg::compute_cycles + 8) begin
    @(posedge clk);
    n++;
    @(negedge clk);
    if (done) break;
  end
  assert (done) else stop_with_failure("done never rose after start was raised");
  assert (n == matmul_pkg::compute_cycles)
  else stop_with_failure($sformatf("Fail done latency: got %0h expected %0h",
                                   n, matmul_pkg::compute_cycles));
  // start is still sampled high on this edge
  @(posedge clk);
  start <= 1'b0;
  @(negedge clk);
  assert (done) else stop_with_failure("done fell while start was still high");
  @(posedge clk);
  @(negedge clk);
  assert (!done) else stop_with_failure("done stayed high after start dropped");
endtask

// back-to-back reads with each word due exactly 2 cycles after its request
task automatic read_c_words();
  matmul_pkg::lane_word_t prev;
  @(negedge clk);
  prev = rd_data;
  for (int k = 0; k <= dim + 2; k++) begin
    @(posedge clk);
    if (k < dim) begin
      host_req.op <= matmul_pkg::op_read_c;
      host_req.addr <= addr_width'(k);
    end else begin
      host_req <= '0;
    end
    @(negedge clk);
    if (k < 2) begin
      assert (rd_data === prev)
      else stop_with_failure("rd_data changed before the 2 cycle read latency");
    end else if (k - 2 < dim) begin
      c_read[k-2] = rd_data;
      for (int r = 0; r < dim; r++) begin
        compare_lane($sformatf("rd_data word %0d lane %0d", k - 2, r),
                     rd_data[r], model_element(r, k - 2));
      end
    end else begin
      assert (rd_data === c_read[dim-1])
      else stop_with_failure("rd_data did not hold the last word after the reads");
    end
  end
endtask

task automatic check_reset_state();
  for (int r = 0; r < dim; r++) begin
    for (int c = 0; c < dim; c++) begin
      a_mat[r][c] = '0;
      b_mat[r][c] = '0;
    end
  end
  @(negedge clk);
  assert (!done) else stop_with_failure("done was high right after reset");
  // C is all zero, so the model gives zero too
  read_c_words();
endtask

task automatic multiply_identity();
  randomize_matrices(0, 16);
  for (int r = 0; r < dim; r++) begin
    for (int c = 0; c < dim; c++) begin
      a_mat[r][c] = (r == c) ? 16'd1 : 16'd0;
    end
  end
  write_matrices(1'b1, 1'b1);
  run_compute();
  read_c_words();
  for (int j = 0; j < dim; j++) begin
    for (int r = 0; r < dim; r++) begin
      compare_lane($sformatf("rd_data word %0d lane %0d", j, r), c_read[j][r], b_mat[r][j]);
    end
  end
endtask

// four products of 7-bit values stay below 16 bits
task automatic multiply_random();
  randomize_matrices(7, 7);
  write_matrices(1'b1, 1'b1);
  run_compute();
  read_c_words();
endtask

task automatic saturate_one_row();
  randomize_matrices(8, 8);
  for (int c = 0; c < dim; c++) begin
    a_mat[0][c] = 16'hFFFF;
    // nonzero B so every row 0 sum overflows
    for (int r = 0; r < dim; r++) begin
      b_mat[r][c] = b_mat[r][c] | 16'd1;
    end
  end
  write_matrices(1'b1, 1'b1);
  run_compute();
  read_c_words();
  for (int j = 0; j < dim; j++) begin
    compare_lane($sformatf("rd_data word %0d lane 0", j), c_read[j][0], 16'hFFFF);
  end
endtask

// A stays from the saturation run
task automatic repeat_with_new_b();
  randomize_matrices(0, 8);
  write_matrices(1'b0, 1'b1);
  run_compute();
  read_c_words();
endtask

`endif

/* test/matmul_tb.sv */
`default_nettype none

module matmul_tb;

  localparam int dim = matmul_pkg::dim;
  localparam int addr_width = matmul_pkg::addr_width;
  localparam int num_tests = 5;
  localparam int watchdog_cycles = num_tests * (matmul_pkg::compute_cycles + 40);

  logic                   clk;
  logic                   reset;
  logic                   start;
  matmul_pkg::host_req_t  host_req;
  matmul_pkg::lane_word_t rd_data;
  logic                   done;

  // test matrices, indexed [row][col]
  logic [15:0]            a_mat [dim][dim];
  logic [15:0]            b_mat [dim][dim];
  // C words as read back, word j is column j
  matmul_pkg::lane_word_t c_read [dim];
  logic [31:0]            lfsr_state;

  matmul_top #(
    .data_width(matmul_pkg::data_width),
    .dim       (dim),
    .addr_width(addr_width)
  ) DUT (
    .clk     (clk),
    .reset   (reset),
    .host_req(host_req),
    .start   (start),
    .rd_data (rd_data),
    .done    (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_with_failure("The test sequence did not finish within the time limit");
  end

  // right-shifting Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [15:0] random_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // unsigned sum of products, wraps at 32 bits, then saturates to 16
  function automatic logic [15:0] model_element(int r, int j);
    logic [31:0] acc;
    acc = '0;
    for (int k = 0; k < dim; k++) begin
      acc = acc + a_mat[r][k] * b_mat[k][j];
    end
    return (acc[31:16] != '0) ? 16'hFFFF : acc[15:0];
  endfunction

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  `include "matmul_tasks.svh"

  initial begin
    reset = 1'b1;
    start = 1'b0;
    host_req = '0;
    lfsr_state = 32'd81492;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    check_reset_state();
    multiply_identity();
    multiply_random();
    saturate_one_row();
    repeat_with_new_b();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+test
logic/matmul_pkg.sv
logic/word_ram.sv
logic/processing_element.sv
logic/systolic_array.sv
logic/matmul_controller.sv
logic/matmul_top.sv
test/matmul_tb.sv

/* Bender.yml */
package:
  name: matmul_systolic

sources:
  - files:
      - logic/matmul_pkg.sv
      - logic/word_ram.sv
      - logic/processing_element.sv
      - logic/systolic_array.sv
      - logic/matmul_controller.sv
      - logic/matmul_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/matmul_tb.sv
